// File: hdl/pcie_rx_pkg.sv
package pcie_rx_pkg;

    localparam int FLOW_IDX_WIDTH  = 6;
    localparam int PKT_SIZE_WIDTH  = 16;
    localparam int MMIO_ADDR_WIDTH = 24;
    localparam int TBL_IDX_WIDTH   = 8;
    localparam int TBL_IDX_LSB     = 12;
    localparam int BYTE_EN_WIDTH   = 64;
    localparam int REG_WIDTH       = 32;
    localparam int RB_SIZE_WIDTH   = 16;
    localparam int REG_ADDR_WIDTH  = 2;

    typedef logic [FLOW_IDX_WIDTH-1:0]  flow_idx_t;
    typedef logic [PKT_SIZE_WIDTH-1:0]  pkt_size_t;
    typedef logic [MMIO_ADDR_WIDTH-1:0] mmio_addr_t;
    typedef logic [TBL_IDX_WIDTH-1:0]   tbl_idx_t;
    typedef logic [BYTE_EN_WIDTH-1:0]   byte_en_t;
    typedef logic [REG_WIDTH-1:0]       reg_t;
    typedef logic [RB_SIZE_WIDTH-1:0]   rb_size_t;
    typedef logic [REG_ADDR_WIDTH-1:0]  reg_addr_t;

    // Queue table layout seen through MMIO. Each field is one 32-bit word.
    localparam int MAX_NB_FLOWS   = 64;
    localparam int REG_SIZE       = 4;
    localparam int HEAD_FIELD_IDX = 1;

    localparam int HEAD_UPD_DEPTH = 128;
    localparam int HEAD_UPD_SLACK = 4;

    // Ordering queue record is {queue_id, size, descriptor_only, needs_dsc}.
    localparam int ORDER_DEPTH       = 8;
    localparam int ORDER_ALMOST_FULL = 4;
    localparam int ORDER_REC_WIDTH   = FLOW_IDX_WIDTH + PKT_SIZE_WIDTH + 2;

    // Control register map.
    localparam int        NB_CTRL_REGS    = 2 ** REG_ADDR_WIDTH;
    localparam reg_addr_t REG_CFG0        = 2'd0;
    localparam reg_addr_t REG_CFG1        = 2'd1;
    localparam int        DISABLE_BIT     = 0;
    localparam int        PKT_RB_SIZE_LSB = 1;
    localparam int        SW_RESET_BIT    = 27;

    typedef enum logic {
        REG_IDLE,
        REG_ACK
    } reg_state_t;

endpackage

// File: hdl/ctrl_regs.sv
`timescale 1ns/1ps

module ctrl_regs (
    input  logic                   pcie_clk,
    input  logic                   pcie_reset_n,

    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  pcie_rx_pkg::reg_addr_t wb_adr,
    input  pcie_rx_pkg::reg_t      wb_dat_w,
    output pcie_rx_pkg::reg_t      wb_dat_r,
    output logic                   wb_ack,

    output logic                   disable_pcie,
    output pcie_rx_pkg::rb_size_t  pkt_rb_size,
    output pcie_rx_pkg::rb_size_t  dsc_rb_size,
    output logic                   sw_reset
);

pcie_rx_pkg::reg_state_t state;
pcie_rx_pkg::reg_t       regs [pcie_rx_pkg::NB_CTRL_REGS];
logic                    sw_reset_r1;

// Every access takes two cycles, the first to see the request and the second to ack it.
always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        state <= pcie_rx_pkg::REG_IDLE;
        for (int i = 0; i < pcie_rx_pkg::NB_CTRL_REGS; i++) begin
            regs[i] <= '0;
        end
    end else begin
        case (state)
            pcie_rx_pkg::REG_IDLE: begin
                if (wb_cyc && wb_stb) begin
                    state <= pcie_rx_pkg::REG_ACK;
                    if (wb_we) begin
                        regs[wb_adr] <= wb_dat_w;
                    end
                end
            end
            pcie_rx_pkg::REG_ACK: begin
                state <= pcie_rx_pkg::REG_IDLE;
            end
        endcase
    end
end

always_ff @(posedge pcie_clk) begin
    if (state == pcie_rx_pkg::REG_IDLE && wb_cyc && wb_stb) begin
        wb_dat_r <= regs[wb_adr];
    end
end

assign wb_ack = (state == pcie_rx_pkg::REG_ACK);

assign disable_pcie = regs[pcie_rx_pkg::REG_CFG0][pcie_rx_pkg::DISABLE_BIT];
assign pkt_rb_size  =
    regs[pcie_rx_pkg::REG_CFG0][pcie_rx_pkg::PKT_RB_SIZE_LSB +: pcie_rx_pkg::RB_SIZE_WIDTH];
assign dsc_rb_size  = regs[pcie_rx_pkg::REG_CFG1][0 +: pcie_rx_pkg::RB_SIZE_WIDTH];

// Software reset stays asserted until software clears the bit again.
always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        sw_reset_r1 <= 1'b0;
        sw_reset    <= 1'b0;
    end else begin
        sw_reset_r1 <= regs[pcie_rx_pkg::REG_CFG0][pcie_rx_pkg::SW_RESET_BIT];
        sw_reset    <= sw_reset_r1;
    end
end

endmodule

// File: hdl/head_upd_detect.sv
`timescale 1ns/1ps

module head_upd_detect (
    input  logic                    pcie_clk,
    input  logic                    pcie_reset_n,

    input  pcie_rx_pkg::mmio_addr_t mmio_address,
    input  logic                    mmio_write,
    input  pcie_rx_pkg::byte_en_t   mmio_byteenable,

    input  pcie_rx_pkg::reg_t       fifo_occup,
    output pcie_rx_pkg::flow_idx_t  push_data,
    output logic                    push_valid,
    output logic                    ignored
);

pcie_rx_pkg::tbl_idx_t tbl_idx;
logic                  head_write;
logic                  almost_full;

assign tbl_idx = mmio_address[pcie_rx_pkg::TBL_IDX_LSB +: pcie_rx_pkg::TBL_IDX_WIDTH];

// Only a write covering the whole head word counts as a head update.
assign head_write = mmio_write && (tbl_idx < pcie_rx_pkg::MAX_NB_FLOWS) &&
    (mmio_byteenable[pcie_rx_pkg::HEAD_FIELD_IDX * pcie_rx_pkg::REG_SIZE
                     +: pcie_rx_pkg::REG_SIZE] == {pcie_rx_pkg::REG_SIZE{1'b1}});

// Leaves room for the push already in flight.
assign almost_full =
    fifo_occup > (pcie_rx_pkg::HEAD_UPD_DEPTH - pcie_rx_pkg::HEAD_UPD_SLACK);

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        push_valid <= 1'b0;
        ignored    <= 1'b0;
    end else begin
        push_valid <= head_write && !almost_full;
        ignored    <= head_write && almost_full;
    end
end

always_ff @(posedge pcie_clk) begin
    push_data <= tbl_idx[pcie_rx_pkg::FLOW_IDX_WIDTH-1:0];
end

endmodule

// File: hdl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
) (
    input  logic              pcie_clk,
    input  logic              pcie_reset_n,

    input  logic [WIDTH-1:0]  in_data,
    input  logic              in_valid,
    output logic              in_ready,

    output logic [WIDTH-1:0]  out_data,
    output logic              out_valid,
    input  logic              out_ready,

    output pcie_rx_pkg::reg_t occup
);

logic [WIDTH-1:0]         mem [DEPTH];
logic [$clog2(DEPTH)-1:0] wr_ptr;
logic [$clog2(DEPTH)-1:0] rd_ptr;
logic [$clog2(DEPTH):0]   mem_cnt;
logic                     push;
logic                     load;

// The output register counts toward the total capacity of DEPTH words.
assign occup    = pcie_rx_pkg::reg_t'(mem_cnt) + pcie_rx_pkg::reg_t'(out_valid);
assign in_ready = occup < DEPTH;
assign push     = in_valid && in_ready;
assign load     = (mem_cnt != '0) && (!out_valid || out_ready);

always_ff @(posedge pcie_clk) begin
    if (push) begin
        mem[wr_ptr] <= in_data;
    end
    if (load) begin
        out_data <= mem[rd_ptr];
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        wr_ptr    <= '0;
        rd_ptr    <= '0;
        mem_cnt   <= '0;
        out_valid <= 1'b0;
    end else begin
        if (push) begin
            wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
        end
        if (load) begin
            rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
        end
        case ({push, load})
            2'b10:   mem_cnt <= mem_cnt + 1'b1;
            2'b01:   mem_cnt <= mem_cnt - 1'b1;
            default: mem_cnt <= mem_cnt;
        endcase
        if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end
end

endmodule

// File: hdl/meta_merge.sv
`timescale 1ns/1ps

module meta_merge (
    input  logic                   pcie_clk,
    input  logic                   pcie_reset_n,

    input  pcie_rx_pkg::flow_idx_t head_data,
    input  logic                   head_valid,
    output logic                   head_ready,

    input  pcie_rx_pkg::flow_idx_t meta_queue_id,
    input  pcie_rx_pkg::pkt_size_t meta_size,
    input  logic                   meta_valid,
    output logic                   meta_ready,

    input  pcie_rx_pkg::reg_t      order_occup,
    output pcie_rx_pkg::flow_idx_t rec_queue_id,
    output pcie_rx_pkg::pkt_size_t rec_size,
    output logic                   rec_descriptor_only,
    output logic                   rec_needs_dsc,
    output logic                   rec_valid,

    output logic                   head_served
);

logic order_almost_full;
logic merge_head_pkt;
logic head_take;
logic meta_take;

assign order_almost_full = order_occup > pcie_rx_pkg::ORDER_ALMOST_FULL;

// Head updates win over metadata, except that a head update and a packet
// for the same queue are folded into a single record.
always_comb begin
    head_ready     = 1'b0;
    meta_ready     = 1'b0;
    merge_head_pkt = 1'b0;
    if (!order_almost_full) begin
        head_ready = 1'b1;
        if (head_valid) begin
            merge_head_pkt = meta_valid && (meta_queue_id == head_data);
            meta_ready     = merge_head_pkt;
        end else begin
            meta_ready = 1'b1;
        end
    end
end

assign head_take = head_valid && head_ready;
assign meta_take = meta_valid && meta_ready;

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        rec_valid   <= 1'b0;
        head_served <= 1'b0;
    end else begin
        rec_valid   <= head_take || meta_take;
        head_served <= head_take;
    end
end

// A packet record carries the merge flag; a lone head becomes a
// descriptor-only record of size zero.
always_ff @(posedge pcie_clk) begin
    if (meta_take) begin
        rec_queue_id        <= meta_queue_id;
        rec_size            <= meta_size;
        rec_descriptor_only <= 1'b0;
        rec_needs_dsc       <= merge_head_pkt;
    end else if (head_take) begin
        rec_queue_id        <= head_data;
        rec_size            <= '0;
        rec_descriptor_only <= 1'b1;
        rec_needs_dsc       <= 1'b0;
    end
end

endmodule

// File: hdl/stat_counters.sv
`timescale 1ns/1ps

module stat_counters (
    input  logic              pcie_clk,
    input  logic              pcie_reset_n,
    input  logic              sw_reset,

    input  logic              ignored,
    input  logic              head_served,

    output pcie_rx_pkg::reg_t rx_ignored_head_cnt,
    output pcie_rx_pkg::reg_t rx_pkt_head_upd_cnt
);

// Ignored heads point at lost descriptors, so software reset keeps them.
always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        rx_ignored_head_cnt <= '0;
    end else if (ignored) begin
        rx_ignored_head_cnt <= rx_ignored_head_cnt + 1'b1;
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n || sw_reset) begin
        rx_pkt_head_upd_cnt <= '0;
    end else if (head_served) begin
        rx_pkt_head_upd_cnt <= rx_pkt_head_upd_cnt + 1'b1;
    end
end

endmodule

// File: hdl/pcie_rx_top.sv
`timescale 1ns/1ps

module pcie_rx_top (
    input  logic                    pcie_clk,
    input  logic                    pcie_reset_n,

    input  pcie_rx_pkg::mmio_addr_t mmio_address,
    input  logic                    mmio_write,
    input  pcie_rx_pkg::byte_en_t   mmio_byteenable,

    input  pcie_rx_pkg::flow_idx_t  meta_in_queue_id,
    input  pcie_rx_pkg::pkt_size_t  meta_in_size,
    input  logic                    meta_in_valid,
    output logic                    meta_in_ready,

    output pcie_rx_pkg::flow_idx_t  out_queue_id,
    output pcie_rx_pkg::pkt_size_t  out_size,
    output logic                    out_descriptor_only,
    output logic                    out_needs_dsc,
    output logic                    out_valid,
    input  logic                    out_ready,

    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  pcie_rx_pkg::reg_addr_t  wb_adr,
    input  pcie_rx_pkg::reg_t       wb_dat_w,
    output pcie_rx_pkg::reg_t       wb_dat_r,
    output logic                    wb_ack,

    output pcie_rx_pkg::reg_t       rx_ignored_head_cnt,
    output pcie_rx_pkg::reg_t       rx_pkt_head_upd_cnt,
    output logic                    disable_pcie,
    output pcie_rx_pkg::rb_size_t   pkt_rb_size,
    output pcie_rx_pkg::rb_size_t   dsc_rb_size,
    output logic                    sw_reset
);

pcie_rx_pkg::flow_idx_t head_in_data;
logic                   head_in_valid;
pcie_rx_pkg::flow_idx_t head_out_data;
logic                   head_out_valid;
logic                   head_out_ready;
pcie_rx_pkg::reg_t      head_occup;
logic                   head_ignored;
logic                   head_served;

pcie_rx_pkg::flow_idx_t rec_queue_id;
pcie_rx_pkg::pkt_size_t rec_size;
logic                   rec_descriptor_only;
logic                   rec_needs_dsc;
logic                   rec_valid;
pcie_rx_pkg::reg_t      order_occup;

logic [pcie_rx_pkg::ORDER_REC_WIDTH-1:0] order_in_data;
logic [pcie_rx_pkg::ORDER_REC_WIDTH-1:0] order_out_data;

assign order_in_data = {rec_queue_id, rec_size, rec_descriptor_only, rec_needs_dsc};
assign {out_queue_id, out_size, out_descriptor_only, out_needs_dsc} = order_out_data;

ctrl_regs u_ctrl_regs (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .disable_pcie (disable_pcie),
    .pkt_rb_size  (pkt_rb_size),
    .dsc_rb_size  (dsc_rb_size),
    .sw_reset     (sw_reset)
);

head_upd_detect u_head_upd_detect (
    .pcie_clk        (pcie_clk),
    .pcie_reset_n    (pcie_reset_n),
    .mmio_address    (mmio_address),
    .mmio_write      (mmio_write),
    .mmio_byteenable (mmio_byteenable),
    .fifo_occup      (head_occup),
    .push_data       (head_in_data),
    .push_valid      (head_in_valid),
    .ignored         (head_ignored)
);

// Head writes have no back-pressure, the detector watches occupancy instead.
sync_fifo #(
    .WIDTH (pcie_rx_pkg::FLOW_IDX_WIDTH),
    .DEPTH (pcie_rx_pkg::HEAD_UPD_DEPTH)
) head_upd_queue (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .in_data      (head_in_data),
    .in_valid     (head_in_valid),
    .in_ready     (),
    .out_data     (head_out_data),
    .out_valid    (head_out_valid),
    .out_ready    (head_out_ready),
    .occup        (head_occup)
);

meta_merge u_meta_merge (
    .pcie_clk            (pcie_clk),
    .pcie_reset_n        (pcie_reset_n),
    .head_data           (head_out_data),
    .head_valid          (head_out_valid),
    .head_ready          (head_out_ready),
    .meta_queue_id       (meta_in_queue_id),
    .meta_size           (meta_in_size),
    .meta_valid          (meta_in_valid),
    .meta_ready          (meta_in_ready),
    .order_occup         (order_occup),
    .rec_queue_id        (rec_queue_id),
    .rec_size            (rec_size),
    .rec_descriptor_only (rec_descriptor_only),
    .rec_needs_dsc       (rec_needs_dsc),
    .rec_valid           (rec_valid),
    .head_served         (head_served)
);

sync_fifo #(
    .WIDTH (pcie_rx_pkg::ORDER_REC_WIDTH),
    .DEPTH (pcie_rx_pkg::ORDER_DEPTH)
) order_queue (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .in_data      (order_in_data),
    .in_valid     (rec_valid),
    .in_ready     (),
    .out_data     (order_out_data),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .occup        (order_occup)
);

stat_counters u_stat_counters (
    .pcie_clk            (pcie_clk),
    .pcie_reset_n        (pcie_reset_n),
    .sw_reset            (sw_reset),
    .ignored             (head_ignored),
    .head_served         (head_served),
    .rx_ignored_head_cnt (rx_ignored_head_cnt),
    .rx_pkt_head_upd_cnt (rx_pkt_head_upd_cnt)
);

endmodule

// File: tb/pcie_rx_model.svh
`ifndef PCIE_RX_MODEL_SVH
`define PCIE_RX_MODEL_SVH

// Expected output streams. Packets and head-update events are each kept
// in their own queue, since only their order within a stream is fixed.
pcie_rx_pkg::flow_idx_t exp_qid_q[$];
pcie_rx_pkg::pkt_size_t exp_size_q[$];
pcie_rx_pkg::flow_idx_t exp_head_q[$];
int                     head_events;

// A head update is a write into the table of a real flow that covers all
// four bytes of the head field (byte lanes 4 to 7).
function automatic logic head_write_valid(input pcie_rx_pkg::mmio_addr_t addr,
                                          input pcie_rx_pkg::byte_en_t   be);
    return (addr[19:12] < pcie_rx_pkg::MAX_NB_FLOWS) && (be[7:4] == 4'hf);
endfunction

function automatic logic model_empty();
    return (exp_qid_q.size() == 0) && (exp_head_q.size() == 0);
endfunction

task automatic check_record(input pcie_rx_pkg::flow_idx_t qid,
                            input pcie_rx_pkg::pkt_size_t size,
                            input logic                   dsc_only,
                            input logic                   needs_dsc);
    if (dsc_only) begin
        if (exp_head_q.size() == 0) begin
            report_error("descriptor-only record with no head update pending");
        end else begin
            compare_flow("descriptor-only queue id", exp_head_q.pop_front(), qid);
            compare_size("descriptor-only size", '0, size);
            compare_flag("descriptor-only needs_dsc", 1'b0, needs_dsc);
            head_events++;
        end
    end else if (exp_qid_q.size() == 0) begin
        report_error("packet record with no metadata pending");
    end else begin
        compare_flow("packet queue id", exp_qid_q.pop_front(), qid);
        compare_size("packet size", exp_size_q.pop_front(), size);
        if (needs_dsc) begin
            // The merged head must be the oldest one still pending.
            if (exp_head_q.size() == 0) begin
                report_error("packet flagged needs_dsc with no head update pending");
            end else begin
                compare_flow("needs_dsc head queue id", exp_head_q.pop_front(), qid);
                head_events++;
            end
        end
    end
endtask

`endif

// File: tb/pcie_rx_tb.sv
`timescale 1ns/1ps

module pcie_rx_tb;

localparam int DRIVE_DLY        = 1;
localparam int RESET_CYCLES     = 4;
localparam int WB_WAIT_CYCLES   = 20;
localparam int META_WAIT_CYCLES = 2000;
localparam int BURST_WRITES     = pcie_rx_pkg::HEAD_UPD_DEPTH + 12;

// Cycle budget of each test. The watchdog allows twice their sum.
localparam int REG_CYCLES      = 300;
localparam int PASS_CYCLES     = 400;
localparam int FILTER_CYCLES   = 200;
localparam int ORDER_CYCLES    = 800;
localparam int BP_CYCLES       = 1200;
localparam int SWRST_CYCLES    = 100;
localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + REG_CYCLES + PASS_CYCLES +
    FILTER_CYCLES + ORDER_CYCLES + BP_CYCLES + SWRST_CYCLES);

logic                   pcie_clk;
logic                   pcie_reset_n;
pcie_rx_pkg::mmio_addr_t mmio_address;
logic                   mmio_write;
pcie_rx_pkg::byte_en_t  mmio_byteenable;
pcie_rx_pkg::flow_idx_t meta_in_queue_id;
pcie_rx_pkg::pkt_size_t meta_in_size;
logic                   meta_in_valid;
logic                   meta_in_ready;
pcie_rx_pkg::flow_idx_t out_queue_id;
pcie_rx_pkg::pkt_size_t out_size;
logic                   out_descriptor_only;
logic                   out_needs_dsc;
logic                   out_valid;
logic                   out_ready;
logic                   wb_cyc;
logic                   wb_stb;
logic                   wb_we;
pcie_rx_pkg::reg_addr_t wb_adr;
pcie_rx_pkg::reg_t      wb_dat_w;
pcie_rx_pkg::reg_t      wb_dat_r;
logic                   wb_ack;
pcie_rx_pkg::reg_t      rx_ignored_head_cnt;
pcie_rx_pkg::reg_t      rx_pkt_head_upd_cnt;
logic                   disable_pcie;
pcie_rx_pkg::rb_size_t  pkt_rb_size;
pcie_rx_pkg::rb_size_t  dsc_rb_size;
logic                   sw_reset;

int    seed;
int    err_cnt;
int    check_cnt;
int    tests_run;
int    test_err_base;
string cur_test;

pcie_rx_top u_pcie_rx_top (.*);

initial begin
    pcie_clk = 1'b0;
    forever #50 pcie_clk = ~pcie_clk;
end

task automatic report_error(input string msg);
    err_cnt++;
    $display("ERROR %s: %s", cur_test, msg);
endtask

task automatic compare_flow(input string what, input pcie_rx_pkg::flow_idx_t exp,
                            input pcie_rx_pkg::flow_idx_t act);
    check_cnt++;
    if (exp !== act) begin
        err_cnt++;
        $display("MISMATCH %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
endtask

task automatic compare_size(input string what, input pcie_rx_pkg::pkt_size_t exp,
                            input pcie_rx_pkg::pkt_size_t act);
    check_cnt++;
    if (exp !== act) begin
        err_cnt++;
        $display("MISMATCH %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
endtask

task automatic compare_flag(input string what, input logic exp, input logic act);
    check_cnt++;
    if (exp !== act) begin
        err_cnt++;
        $display("MISMATCH %s %s: expected %0b, actual %0b", cur_test, what, exp, act);
    end
endtask

task automatic compare_reg(input string what, input pcie_rx_pkg::reg_t exp,
                           input pcie_rx_pkg::reg_t act);
    check_cnt++;
    if (exp !== act) begin
        err_cnt++;
        $display("MISMATCH %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
    end
endtask

task automatic compare_rb(input string what, input pcie_rx_pkg::rb_size_t exp,
                          input pcie_rx_pkg::rb_size_t act);
    check_cnt++;
    if (exp !== act) begin
        err_cnt++;
        $display("MISMATCH %s %s: expected 0x%04h, actual 0x%04h", cur_test, what, exp, act);
    end
endtask

`include "pcie_rx_model.svh"

always @(negedge pcie_clk) begin
    if (pcie_reset_n && out_valid && out_ready) begin
        check_record(out_queue_id, out_size, out_descriptor_only, out_needs_dsc);
    end
end

function automatic int rand_range(input int n);
    return int'({$random(seed)} % n);
endfunction

function automatic pcie_rx_pkg::mmio_addr_t head_addr(input pcie_rx_pkg::tbl_idx_t idx);
    pcie_rx_pkg::mmio_addr_t addr;
    addr        = pcie_rx_pkg::mmio_addr_t'($random(seed));
    addr[19:12] = idx;
    return addr;
endfunction

function automatic pcie_rx_pkg::byte_en_t full_head_lanes();
    pcie_rx_pkg::byte_en_t be;
    be      = pcie_rx_pkg::byte_en_t'({$random(seed), $random(seed)});
    be[7:4] = 4'hf;
    return be;
endfunction

task automatic begin_test(input string name);
    cur_test      = name;
    test_err_base = err_cnt;
endtask

task automatic end_test();
    tests_run++;
    if (err_cnt == test_err_base) begin
        $display("Test %0d %s: passed", tests_run, cur_test);
    end else begin
        $display("Test %0d %s: failed with %0d errors", tests_run, cur_test,
                 err_cnt - test_err_base);
    end
endtask

task automatic wb_access(input logic we, input pcie_rx_pkg::reg_addr_t adr,
                         input pcie_rx_pkg::reg_t wdata, output pcie_rx_pkg::reg_t rdata);
    int waited;
    waited = 0;
    @(posedge pcie_clk);
    #DRIVE_DLY;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    @(negedge pcie_clk);
    while (!wb_ack && waited < WB_WAIT_CYCLES) begin
        @(negedge pcie_clk);
        waited++;
    end
    rdata = wb_dat_r;
    if (!wb_ack) begin
        report_error("Wishbone access was never acknowledged");
    end
    @(posedge pcie_clk);
    #DRIVE_DLY;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge pcie_clk);
    if (wb_ack) begin
        report_error("Wishbone ack stayed high for more than one cycle");
    end
endtask

task automatic head_write(input pcie_rx_pkg::mmio_addr_t addr, input pcie_rx_pkg::byte_en_t be);
    @(posedge pcie_clk);
    #DRIVE_DLY;
    mmio_address    = addr;
    mmio_byteenable = be;
    mmio_write      = 1'b1;
    if (head_write_valid(addr, be)) begin
        exp_head_q.push_back(addr[17:12]);
    end
    @(posedge pcie_clk);
    #DRIVE_DLY;
    mmio_write = 1'b0;
endtask

task automatic send_meta(input pcie_rx_pkg::flow_idx_t qid, input pcie_rx_pkg::pkt_size_t size);
    int waited;
    waited = 0;
    @(posedge pcie_clk);
    #DRIVE_DLY;
    meta_in_queue_id = qid;
    meta_in_size     = size;
    meta_in_valid    = 1'b1;
    @(negedge pcie_clk);
    while (!meta_in_ready && waited < META_WAIT_CYCLES) begin
        @(negedge pcie_clk);
        waited++;
    end
    if (meta_in_ready) begin
        exp_qid_q.push_back(qid);
        exp_size_q.push_back(size);
    end else begin
        report_error("metadata transfer was never accepted");
    end
    @(posedge pcie_clk);
    #DRIVE_DLY;
    meta_in_valid = 1'b0;
endtask

task automatic wait_drained(input int budget);
    int waited;
    waited = 0;
    while ((!model_empty() || out_valid) && waited < budget) begin
        @(negedge pcie_clk);
        waited++;
    end
    if (!model_empty() || out_valid) begin
        report_error("expected records did not reach the output in time");
    end
endtask

task automatic reg_access_test();
    pcie_rx_pkg::reg_t      shadow [4];
    pcie_rx_pkg::reg_t      wdata;
    pcie_rx_pkg::reg_t      rdata;
    pcie_rx_pkg::reg_addr_t adr;
    begin_test("register access");
    for (int i = 0; i < 4; i++) begin
        shadow[i] = '0;
    end
    for (int i = 0; i < 16; i++) begin
        adr   = pcie_rx_pkg::reg_addr_t'(i);
        wdata = pcie_rx_pkg::reg_t'($random(seed));
        // Software reset would clear the head-update counter.
        if (adr == 2'd0) begin
            wdata[pcie_rx_pkg::SW_RESET_BIT] = 1'b0;
        end
        wb_access(1'b1, adr, wdata, rdata);
        shadow[adr] = wdata;
        wb_access(1'b0, adr, '0, rdata);
        compare_reg("register readback", wdata, rdata);
        compare_flag("disable_pcie", shadow[0][0], disable_pcie);
        compare_rb("pkt_rb_size", shadow[0][16:1], pkt_rb_size);
        compare_rb("dsc_rb_size", shadow[1][15:0], dsc_rb_size);
    end
    end_test();
endtask

task automatic passthrough_test();
    begin_test("packet pass-through");
    for (int i = 0; i < 30; i++) begin
        send_meta(pcie_rx_pkg::flow_idx_t'($random(seed)), pcie_rx_pkg::pkt_size_t'($random(seed)));
    end
    wait_drained(PASS_CYCLES);
    end_test();
endtask

task automatic filter_test();
    pcie_rx_pkg::reg_t     ign_base;
    pcie_rx_pkg::reg_t     upd_base;
    pcie_rx_pkg::byte_en_t be;
    pcie_rx_pkg::tbl_idx_t idx;
    begin_test("head-write filtering");
    ign_base = rx_ignored_head_cnt;
    upd_base = rx_pkt_head_upd_cnt;
    for (int i = 0; i < 16; i++) begin
        if (i % 2 == 0) begin
            idx = pcie_rx_pkg::tbl_idx_t'(pcie_rx_pkg::MAX_NB_FLOWS + rand_range(192));
            be  = '1;
        end else begin
            idx = pcie_rx_pkg::tbl_idx_t'(rand_range(pcie_rx_pkg::MAX_NB_FLOWS));
            be  = full_head_lanes();
            be[4 + rand_range(4)] = 1'b0;
        end
        head_write(head_addr(idx), be);
    end
    // Nothing may come out, so wait well past the longest head latency.
    repeat (20) @(negedge pcie_clk);
    compare_reg("ignored head count", ign_base, rx_ignored_head_cnt);
    compare_reg("head update count", upd_base, rx_pkt_head_upd_cnt);
    end_test();
endtask

task automatic head_order_test();
    begin_test("head-update ordering");
    fork
        for (int i = 0; i < 24; i++) begin
            repeat (rand_range(3)) @(posedge pcie_clk);
            head_write(head_addr(pcie_rx_pkg::tbl_idx_t'(rand_range(4))), full_head_lanes());
        end
        for (int i = 0; i < 30; i++) begin
            send_meta(pcie_rx_pkg::flow_idx_t'(rand_range(4)),
                      pcie_rx_pkg::pkt_size_t'($random(seed)));
        end
    join
    wait_drained(ORDER_CYCLES);
    repeat (2) @(negedge pcie_clk);
    compare_reg("head update count", pcie_rx_pkg::reg_t'(head_events), rx_pkt_head_upd_cnt);
    end_test();
endtask

task automatic backpressure_test();
    pcie_rx_pkg::flow_idx_t qid;
    pcie_rx_pkg::reg_t      ign_base;
    pcie_rx_pkg::reg_t      seen;
    int                     ev_base;
    int                     waited;
    begin_test("back-pressure");
    qid      = pcie_rx_pkg::flow_idx_t'(rand_range(pcie_rx_pkg::MAX_NB_FLOWS));
    ign_base = rx_ignored_head_cnt;
    ev_base  = head_events;
    @(posedge pcie_clk);
    #DRIVE_DLY;
    out_ready = 1'b0;
    // Every head write targets one queue, so dropped heads cannot reorder ids.
    fork
        begin
            for (int i = 0; i < BURST_WRITES; i++) begin
                head_write(head_addr({2'b00, qid}), full_head_lanes());
            end
            out_ready = 1'b1;
        end
        for (int i = 0; i < 8; i++) begin
            send_meta(pcie_rx_pkg::flow_idx_t'($random(seed)),
                      pcie_rx_pkg::pkt_size_t'($random(seed)));
        end
    join
    waited = 0;
    seen   = pcie_rx_pkg::reg_t'(head_events - ev_base) + rx_ignored_head_cnt - ign_base;
    while ((exp_qid_q.size() != 0 || seen != BURST_WRITES) && waited < BP_CYCLES) begin
        @(negedge pcie_clk);
        waited++;
        seen = pcie_rx_pkg::reg_t'(head_events - ev_base) + rx_ignored_head_cnt - ign_base;
    end
    compare_reg("head events plus ignored heads", BURST_WRITES, seen);
    compare_reg("metadata not delivered", '0, pcie_rx_pkg::reg_t'(exp_qid_q.size()));
    compare_reg("head update count", pcie_rx_pkg::reg_t'(head_events), rx_pkt_head_upd_cnt);
    exp_head_q.delete();
    end_test();
endtask

task automatic sw_reset_test();
    pcie_rx_pkg::reg_t ign_keep;
    pcie_rx_pkg::reg_t rdata;
    int                waited;
    begin_test("software reset");
    ign_keep = rx_ignored_head_cnt;
    wb_access(1'b1, 2'd0, pcie_rx_pkg::reg_t'(1) << pcie_rx_pkg::SW_RESET_BIT, rdata);
    waited = 0;
    while (!sw_reset && waited < SWRST_CYCLES / 2) begin
        @(negedge pcie_clk);
        waited++;
    end
    if (!sw_reset) begin
        report_error("sw_reset never rose after the reset bit was set");
    end
    wb_access(1'b1, 2'd0, '0, rdata);
    waited = 0;
    while (sw_reset && waited < SWRST_CYCLES / 2) begin
        @(negedge pcie_clk);
        waited++;
    end
    if (sw_reset) begin
        report_error("sw_reset stayed high after the reset bit was cleared");
    end
    @(negedge pcie_clk);
    compare_reg("head update count", '0, rx_pkt_head_upd_cnt);
    compare_reg("ignored head count", ign_keep, rx_ignored_head_cnt);
    end_test();
endtask

initial begin
    seed             = 43;
    err_cnt          = 0;
    check_cnt        = 0;
    tests_run        = 0;
    test_err_base    = 0;
    head_events      = 0;
    cur_test         = "reset";
    pcie_reset_n     = 1'b0;
    mmio_address     = '0;
    mmio_write       = 1'b0;
    mmio_byteenable  = '0;
    meta_in_queue_id = '0;
    meta_in_size     = '0;
    meta_in_valid    = 1'b0;
    out_ready        = 1'b1;
    wb_cyc           = 1'b0;
    wb_stb           = 1'b0;
    wb_we            = 1'b0;
    wb_adr           = '0;
    wb_dat_w         = '0;
    repeat (RESET_CYCLES) @(posedge pcie_clk);
    #DRIVE_DLY;
    pcie_reset_n = 1'b1;

    reg_access_test();
    passthrough_test();
    filter_test();
    head_order_test();
    backpressure_test();
    sw_reset_test();

    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, check_cnt, err_cnt);
    if (err_cnt == 0) begin
        $display("Done: no errors");
    end else begin
        $display("Done: errors found");
    end
    $finish;
end

initial begin
    repeat (WATCHDOG_CYCLES) @(posedge pcie_clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
end

endmodule

// File: tb.f
+incdir+tb
hdl/pcie_rx_pkg.sv
hdl/ctrl_regs.sv
hdl/head_upd_detect.sv
hdl/sync_fifo.sv
hdl/meta_merge.sv
hdl/stat_counters.sv
hdl/pcie_rx_top.sv
tb/pcie_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module pcie_rx_tb -f tb.f -Mdir obj_dir > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vpcie_rx_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" sim.log; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed"
exit 1
